// ==== logic/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and instruction word width
`define CPU_XLEN 32

// architectural register count
`define CPU_NREGS 32

// register index width
`define CPU_REG_AW 5

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== logic/cpu_pipe_pkg.sv ====
`include "cpu_config.svh"

package cpu_pipe_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_OR   = 4'd1,
        ALU_AND  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_ADD  = 4'd5,
        ALU_SUB  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_LUI  = 4'd9
    } alu_op_e;

endpackage

// ==== logic/cpu_isa_pkg.sv ====
`include "cpu_config.svh"

package cpu_isa_pkg;

    // primary opcodes that are decoded
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27
    } funct_e;

    typedef logic [`CPU_REG_AW-1:0] reg_field_t;
    typedef logic [4:0]             shamt_t;
    typedef logic [15:0]            imm_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_field_t rs;
        reg_field_t rt;
        reg_field_t rd;
        shamt_t     shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_field_t rs;
        reg_field_t rt;
        imm_t       imm;
    } i_fmt_t;

    // same fetched word, seen as either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

endpackage

// ==== logic/pc_fetch.sv ====
`include "cpu_config.svh"

module pc_fetch (
    input  logic                clk,
    input  logic                arst_n_i,
    output cpu_pipe_pkg::word_t rom_addr_o,
    output logic                rom_ce_o,
    output cpu_pipe_pkg::word_t if_pc_o,
    input  cpu_pipe_pkg::word_t rom_data_i,
    output cpu_pipe_pkg::word_t if_inst_o
);

    // pc, chip enable and the fetch/decode latch
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_ce_o   <= 1'b0;
            rom_addr_o <= `CPU_RESET_PC;
            if_pc_o    <= `CPU_RESET_PC;
            if_inst_o  <= '0;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o) begin
                rom_addr_o <= rom_addr_o + `CPU_XLEN'(4);
            end
            if_pc_o <= rom_addr_o;
            // nothing valid on the rom bus while disabled, so feed a nop
            if_inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

    // word aligned fetch addresses
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rom_ce_o |-> (rom_addr_o[1:0] == 2'b00)
    );

    // one word per enabled cycle, no skips or repeats
    a_pc_step : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rom_ce_o |=> (rom_addr_o == $past(rom_addr_o) + `CPU_XLEN'(4))
    );

endmodule

// ==== logic/regfile.sv ====
`include "cpu_config.svh"

module regfile (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    wr_en_i,
    input  cpu_pipe_pkg::reg_addr_t wr_addr_i,
    input  cpu_pipe_pkg::word_t     wr_data_i,
    input  logic                    rd_en_a_i,
    input  cpu_pipe_pkg::reg_addr_t rd_addr_a_i,
    input  logic                    rd_en_b_i,
    input  cpu_pipe_pkg::reg_addr_t rd_addr_b_i,
    output cpu_pipe_pkg::word_t     rd_data_a_o,
    output cpu_pipe_pkg::word_t     rd_data_b_o
);

    cpu_pipe_pkg::word_t regs [`CPU_NREGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // r0 is hardwired, a same-cycle write wins over the stored word
    function automatic cpu_pipe_pkg::word_t read_port(
        input logic                    en,
        input cpu_pipe_pkg::reg_addr_t addr
    );
        if (!en || addr == '0) begin
            return '0;
        end
        if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a_o = read_port(rd_en_a_i, rd_addr_a_i);
        rd_data_b_o = read_port(rd_en_b_i, rd_addr_b_i);
    end

    // decode drops r0 writes before they enter the pipe
    a_no_r0_write : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wr_en_i |-> (wr_addr_i != '0)
    );

endmodule

// ==== logic/decode.sv ====
module decode (
    input  cpu_pipe_pkg::word_t     if_pc_i,
    input  cpu_pipe_pkg::word_t     if_inst_i,
    output logic                    rd_en_a_o,
    output cpu_pipe_pkg::reg_addr_t rd_addr_a_o,
    output logic                    rd_en_b_o,
    output cpu_pipe_pkg::reg_addr_t rd_addr_b_o,
    input  cpu_pipe_pkg::word_t     rd_data_a_i,
    input  cpu_pipe_pkg::word_t     rd_data_b_i,
    input  logic                    ex_wr_en_i,
    input  cpu_pipe_pkg::reg_addr_t ex_wr_addr_i,
    input  cpu_pipe_pkg::word_t     ex_wr_data_i,
    input  logic                    mem_wr_en_i,
    input  cpu_pipe_pkg::reg_addr_t mem_wr_addr_i,
    input  cpu_pipe_pkg::word_t     mem_wr_data_i,
    output cpu_pipe_pkg::alu_op_e   alu_op_o,
    output cpu_pipe_pkg::word_t     op_a_o,
    output cpu_pipe_pkg::word_t     op_b_o,
    output logic                    wr_en_o,
    output cpu_pipe_pkg::reg_addr_t wr_addr_o
);

    cpu_isa_pkg::inst_t      inst;
    logic                    is_shift;
    logic                    is_imm;
    logic                    dec_wr;
    cpu_pipe_pkg::reg_addr_t dest;
    cpu_pipe_pkg::word_t     imm_ext;
    cpu_pipe_pkg::word_t     src_a;
    cpu_pipe_pkg::word_t     src_b;

    assign inst = if_inst_i;

    // youngest producer first: execute, then memory, then the register file
    function automatic cpu_pipe_pkg::word_t forward(
        input logic                    en,
        input cpu_pipe_pkg::reg_addr_t addr,
        input cpu_pipe_pkg::word_t     rf_data
    );
        if (en && ex_wr_en_i && ex_wr_addr_i == addr) begin
            return ex_wr_data_i;
        end
        if (en && mem_wr_en_i && mem_wr_addr_i == addr) begin
            return mem_wr_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rd_en_a_o   = 1'b0;
        rd_en_b_o   = 1'b0;
        rd_addr_a_o = inst.r.rs;
        rd_addr_b_o = inst.r.rt;
        alu_op_o    = cpu_pipe_pkg::ALU_NONE;
        is_shift    = 1'b0;
        is_imm      = 1'b0;
        dec_wr      = 1'b0;
        dest        = inst.i.rt;
        case (inst.i.opcode)
            cpu_isa_pkg::OP_SPECIAL: begin
                dest      = inst.r.rd;
                dec_wr    = 1'b1;
                rd_en_a_o = 1'b1;
                rd_en_b_o = 1'b1;
                case (inst.r.funct)
                    cpu_isa_pkg::F_OR:   alu_op_o = cpu_pipe_pkg::ALU_OR;
                    cpu_isa_pkg::F_AND:  alu_op_o = cpu_pipe_pkg::ALU_AND;
                    cpu_isa_pkg::F_XOR:  alu_op_o = cpu_pipe_pkg::ALU_XOR;
                    cpu_isa_pkg::F_NOR:  alu_op_o = cpu_pipe_pkg::ALU_NOR;
                    cpu_isa_pkg::F_ADDU: alu_op_o = cpu_pipe_pkg::ALU_ADD;
                    cpu_isa_pkg::F_SUBU: alu_op_o = cpu_pipe_pkg::ALU_SUB;
                    cpu_isa_pkg::F_SLL: begin
                        alu_op_o  = cpu_pipe_pkg::ALU_SLL;
                        is_shift  = 1'b1;
                        rd_en_a_o = 1'b0;
                    end
                    cpu_isa_pkg::F_SRL: begin
                        alu_op_o  = cpu_pipe_pkg::ALU_SRL;
                        is_shift  = 1'b1;
                        rd_en_a_o = 1'b0;
                    end
                    default: begin
                        dec_wr    = 1'b0;
                        rd_en_a_o = 1'b0;
                        rd_en_b_o = 1'b0;
                    end
                endcase
            end
            cpu_isa_pkg::OP_ORI: begin
                alu_op_o  = cpu_pipe_pkg::ALU_OR;
                is_imm    = 1'b1;
                rd_en_a_o = 1'b1;
                dec_wr    = 1'b1;
            end
            cpu_isa_pkg::OP_ANDI: begin
                alu_op_o  = cpu_pipe_pkg::ALU_AND;
                is_imm    = 1'b1;
                rd_en_a_o = 1'b1;
                dec_wr    = 1'b1;
            end
            cpu_isa_pkg::OP_XORI: begin
                alu_op_o  = cpu_pipe_pkg::ALU_XOR;
                is_imm    = 1'b1;
                rd_en_a_o = 1'b1;
                dec_wr    = 1'b1;
            end
            cpu_isa_pkg::OP_LUI: begin
                alu_op_o = cpu_pipe_pkg::ALU_LUI;
                is_imm   = 1'b1;
                dec_wr   = 1'b1;
            end
            // anything else falls through as a nop
            default: ;
        endcase
    end

    always_comb begin
        src_a = forward(rd_en_a_o, rd_addr_a_o, rd_data_a_i);
        src_b = forward(rd_en_b_o, rd_addr_b_o, rd_data_b_i);
        // lui places the immediate in the upper half
        if (alu_op_o == cpu_pipe_pkg::ALU_LUI) begin
            imm_ext = {inst.i.imm, 16'h0000};
        end else begin
            imm_ext = cpu_pipe_pkg::word_t'(inst.i.imm);
        end
        op_a_o = is_shift ? cpu_pipe_pkg::word_t'(inst.r.shamt) : src_a;
        op_b_o = is_imm ? imm_ext : src_b;
    end

    // r0 is never written
    assign wr_en_o   = dec_wr && (dest != '0);
    assign wr_addr_o = dest;

endmodule

// ==== logic/execute.sv ====
`include "cpu_config.svh"

module execute (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  cpu_pipe_pkg::alu_op_e   alu_op_i,
    input  cpu_pipe_pkg::word_t     op_a_i,
    input  cpu_pipe_pkg::word_t     op_b_i,
    input  logic                    wr_en_i,
    input  cpu_pipe_pkg::reg_addr_t wr_addr_i,
    output logic                    ex_wr_en_o,
    output cpu_pipe_pkg::reg_addr_t ex_wr_addr_o,
    output cpu_pipe_pkg::word_t     ex_wr_data_o
);

    localparam int unsigned SHAMT_W = $clog2(`CPU_XLEN);

    cpu_pipe_pkg::alu_op_e   alu_q;
    logic                    wr_en_q;
    cpu_pipe_pkg::word_t     op_a_q;
    cpu_pipe_pkg::word_t     op_b_q;
    cpu_pipe_pkg::reg_addr_t wr_addr_q;

    // decode/execute latch, control part
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_q   <= cpu_pipe_pkg::ALU_NONE;
            wr_en_q <= 1'b0;
        end else begin
            alu_q   <= alu_op_i;
            wr_en_q <= wr_en_i;
        end
    end

    // operands and destination
    always_ff @(posedge clk) begin
        op_a_q    <= op_a_i;
        op_b_q    <= op_b_i;
        wr_addr_q <= wr_addr_i;
    end

    always_comb begin
        case (alu_q)
            cpu_pipe_pkg::ALU_OR:  ex_wr_data_o = op_a_q | op_b_q;
            cpu_pipe_pkg::ALU_AND: ex_wr_data_o = op_a_q & op_b_q;
            cpu_pipe_pkg::ALU_XOR: ex_wr_data_o = op_a_q ^ op_b_q;
            cpu_pipe_pkg::ALU_NOR: ex_wr_data_o = ~(op_a_q | op_b_q);
            // add and sub wrap at the word width
            cpu_pipe_pkg::ALU_ADD: ex_wr_data_o = op_a_q + op_b_q;
            cpu_pipe_pkg::ALU_SUB: ex_wr_data_o = op_a_q - op_b_q;
            // shift amount rides in operand a
            cpu_pipe_pkg::ALU_SLL: ex_wr_data_o = op_b_q << op_a_q[SHAMT_W-1:0];
            cpu_pipe_pkg::ALU_SRL: ex_wr_data_o = op_b_q >> op_a_q[SHAMT_W-1:0];
            cpu_pipe_pkg::ALU_LUI: ex_wr_data_o = op_b_q;
            default:               ex_wr_data_o = '0;
        endcase
    end

    assign ex_wr_en_o   = wr_en_q;
    assign ex_wr_addr_o = wr_addr_q;

    // decode only raises a write together with a real operation
    a_write_has_op : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wr_en_q |-> (!$isunknown(alu_q) && alu_q != cpu_pipe_pkg::ALU_NONE)
    );

endmodule

// ==== logic/writeback_pipe.sv ====
module writeback_pipe (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    ex_wr_en_i,
    input  cpu_pipe_pkg::reg_addr_t ex_wr_addr_i,
    input  cpu_pipe_pkg::word_t     ex_wr_data_i,
    output logic                    mem_wr_en_o,
    output cpu_pipe_pkg::reg_addr_t mem_wr_addr_o,
    output cpu_pipe_pkg::word_t     mem_wr_data_o,
    output logic                    wb_wr_en_o,
    output cpu_pipe_pkg::reg_addr_t wb_wr_addr_o,
    output cpu_pipe_pkg::word_t     wb_wr_data_o
);

    // write strobes through memory and writeback
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wr_en_o <= 1'b0;
            wb_wr_en_o  <= 1'b0;
        end else begin
            mem_wr_en_o <= ex_wr_en_i;
            wb_wr_en_o  <= mem_wr_en_o;
        end
    end

    // address and result follow their strobes
    always_ff @(posedge clk) begin
        mem_wr_addr_o <= ex_wr_addr_i;
        mem_wr_data_o <= ex_wr_data_i;
        wb_wr_addr_o  <= mem_wr_addr_o;
        wb_wr_data_o  <= mem_wr_data_o;
    end

    // a committed write must carry a clean address and result
    a_wb_known : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wb_wr_en_o |-> !$isunknown({wb_wr_addr_o, wb_wr_data_o})
    );

    // same for the value offered to forwarding
    a_mem_known : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_wr_en_o |-> !$isunknown({mem_wr_addr_o, mem_wr_data_o})
    );

endmodule

// ==== logic/cpu.sv ====
module cpu (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  cpu_pipe_pkg::word_t     rom_data_i,
    output cpu_pipe_pkg::word_t     rom_addr_o,
    output logic                    rom_ce_o,
    output logic                    commit_we_o,
    output cpu_pipe_pkg::reg_addr_t commit_addr_o,
    output cpu_pipe_pkg::word_t     commit_data_o
);

    // fetch to decode
    cpu_pipe_pkg::word_t     if_pc;
    cpu_isa_pkg::inst_t      if_inst;

    // decode and register file
    logic                    rd_en_a;
    cpu_pipe_pkg::reg_addr_t rd_addr_a;
    logic                    rd_en_b;
    cpu_pipe_pkg::reg_addr_t rd_addr_b;
    cpu_pipe_pkg::word_t     rd_data_a;
    cpu_pipe_pkg::word_t     rd_data_b;

    // decode to execute
    cpu_pipe_pkg::alu_op_e   alu_op;
    cpu_pipe_pkg::word_t     op_a;
    cpu_pipe_pkg::word_t     op_b;
    logic                    wr_en;
    cpu_pipe_pkg::reg_addr_t wr_addr;

    // result triples per stage
    logic                    ex_wr_en;
    cpu_pipe_pkg::reg_addr_t ex_wr_addr;
    cpu_pipe_pkg::word_t     ex_wr_data;
    logic                    mem_wr_en;
    cpu_pipe_pkg::reg_addr_t mem_wr_addr;
    cpu_pipe_pkg::word_t     mem_wr_data;
    logic                    wb_wr_en;
    cpu_pipe_pkg::reg_addr_t wb_wr_addr;
    cpu_pipe_pkg::word_t     wb_wr_data;

    pc_fetch pc_fetch_instance (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .if_pc_o    (if_pc),
        .rom_data_i (rom_data_i),
        .if_inst_o  (if_inst)
    );

    regfile regfile_instance (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wr_en_i     (wb_wr_en),
        .wr_addr_i   (wb_wr_addr),
        .wr_data_i   (wb_wr_data),
        .rd_en_a_i   (rd_en_a),
        .rd_addr_a_i (rd_addr_a),
        .rd_en_b_i   (rd_en_b),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b)
    );

    decode decode_instance (
        .if_pc_i       (if_pc),
        .if_inst_i     (if_inst),
        .rd_en_a_o     (rd_en_a),
        .rd_addr_a_o   (rd_addr_a),
        .rd_en_b_o     (rd_en_b),
        .rd_addr_b_o   (rd_addr_b),
        .rd_data_a_i   (rd_data_a),
        .rd_data_b_i   (rd_data_b),
        .ex_wr_en_i    (ex_wr_en),
        .ex_wr_addr_i  (ex_wr_addr),
        .ex_wr_data_i  (ex_wr_data),
        .mem_wr_en_i   (mem_wr_en),
        .mem_wr_addr_i (mem_wr_addr),
        .mem_wr_data_i (mem_wr_data),
        .alu_op_o      (alu_op),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr)
    );

    execute execute_instance (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .alu_op_i     (alu_op),
        .op_a_i       (op_a),
        .op_b_i       (op_b),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .ex_wr_en_o   (ex_wr_en),
        .ex_wr_addr_o (ex_wr_addr),
        .ex_wr_data_o (ex_wr_data)
    );

    writeback_pipe writeback_pipe_instance (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ex_wr_en_i    (ex_wr_en),
        .ex_wr_addr_i  (ex_wr_addr),
        .ex_wr_data_i  (ex_wr_data),
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_wr_data_o (mem_wr_data),
        .wb_wr_en_o    (wb_wr_en),
        .wb_wr_addr_o  (wb_wr_addr),
        .wb_wr_data_o  (wb_wr_data)
    );

    // writeback doubles as the commit trace
    assign commit_we_o   = wb_wr_en;
    assign commit_addr_o = wb_wr_addr;
    assign commit_data_o = wb_wr_data;

endmodule

// ==== verif/cpu_tb.sv ====
`include "cpu_config.svh"

module cpu_tb;

    localparam int NPROG = 64;

    // instruction kinds used to assemble the program
    localparam int K_NOP   = 0;
    localparam int K_ORI   = 1;
    localparam int K_ANDI  = 2;
    localparam int K_XORI  = 3;
    localparam int K_LUI   = 4;
    localparam int K_OR    = 5;
    localparam int K_AND   = 6;
    localparam int K_XOR   = 7;
    localparam int K_NOR   = 8;
    localparam int K_ADDU  = 9;
    localparam int K_SUBU  = 10;
    localparam int K_SLL   = 11;
    localparam int K_SRL   = 12;
    localparam int K_BADOP = 13;
    localparam int K_BADFN = 14;

    logic                    clk;
    logic                    arst_n_i;
    cpu_pipe_pkg::word_t     rom_data_i;
    cpu_pipe_pkg::word_t     rom_addr_o;
    logic                    rom_ce_o;
    logic                    commit_we_o;
    cpu_pipe_pkg::reg_addr_t commit_addr_o;
    cpu_pipe_pkg::word_t     commit_data_o;

    // program table with expected results
    cpu_pipe_pkg::word_t     inst_tab [NPROG];
    logic                    exp_we [NPROG];
    cpu_pipe_pkg::reg_addr_t exp_reg [NPROG];
    cpu_pipe_pkg::word_t     exp_val [NPROG];
    int                      issue_cyc [NPROG];
    int                      n_prog;
    int                      exp_q [$];

    cpu_pipe_pkg::word_t     ref_regs [`CPU_NREGS];
    logic [15:0]             lfsr_state;
    int                      cyc;
    int                      n_checks;
    int                      n_value_err;
    int                      n_other_err;
    logic                    seen_first;
    cpu_pipe_pkg::word_t     prev_addr;

    cpu cpu_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .rom_data_i    (rom_data_i),
        .rom_addr_o    (rom_addr_o),
        .rom_ce_o      (rom_ce_o),
        .commit_we_o   (commit_we_o),
        .commit_addr_o (commit_addr_o),
        .commit_data_o (commit_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[14:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic cpu_pipe_pkg::word_t r_word(
        input logic [5:0] fn,
        input int         s,
        input int         t,
        input int         d,
        input logic [4:0] sh
    );
        cpu_isa_pkg::r_fmt_t r;
        r.opcode = cpu_isa_pkg::OP_SPECIAL;
        r.rs     = s[4:0];
        r.rt     = t[4:0];
        r.rd     = d[4:0];
        r.shamt  = sh;
        r.funct  = cpu_isa_pkg::funct_e'(fn);
        return r;
    endfunction

    function automatic cpu_pipe_pkg::word_t i_word(
        input logic [5:0]  opc,
        input int          s,
        input int          t,
        input logic [15:0] imm
    );
        cpu_isa_pkg::i_fmt_t i;
        i.opcode = cpu_isa_pkg::opcode_e'(opc);
        i.rs     = s[4:0];
        i.rt     = t[4:0];
        i.imm    = imm;
        return i;
    endfunction

    // append one instruction and its expected commit; d is rt for i-type, rd for r-type
    task automatic add_instr(input int kind, input int d, input int s, input int t);
        logic [15:0]         imm;
        logic [15:0]         tmp;
        logic [4:0]          sh;
        cpu_pipe_pkg::word_t a;
        cpu_pipe_pkg::word_t b;
        cpu_pipe_pkg::word_t w;
        cpu_pipe_pkg::word_t v;
        logic                we;
        imm = '0;
        sh  = '0;
        v   = '0;
        a   = ref_regs[s];
        b   = ref_regs[t];
        if ((kind >= K_ORI && kind <= K_LUI) || kind == K_BADOP) begin
            imm = lfsr_bits(16);
        end
        if (kind == K_SLL || kind == K_SRL) begin
            tmp = lfsr_bits(5);
            sh  = tmp[4:0];
        end
        case (kind)
            K_ORI:   w = i_word(cpu_isa_pkg::OP_ORI, s, d, imm);
            K_ANDI:  w = i_word(cpu_isa_pkg::OP_ANDI, s, d, imm);
            K_XORI:  w = i_word(cpu_isa_pkg::OP_XORI, s, d, imm);
            K_LUI:   w = i_word(cpu_isa_pkg::OP_LUI, 0, d, imm);
            K_OR:    w = r_word(cpu_isa_pkg::F_OR, s, t, d, 5'd0);
            K_AND:   w = r_word(cpu_isa_pkg::F_AND, s, t, d, 5'd0);
            K_XOR:   w = r_word(cpu_isa_pkg::F_XOR, s, t, d, 5'd0);
            K_NOR:   w = r_word(cpu_isa_pkg::F_NOR, s, t, d, 5'd0);
            K_ADDU:  w = r_word(cpu_isa_pkg::F_ADDU, s, t, d, 5'd0);
            K_SUBU:  w = r_word(cpu_isa_pkg::F_SUBU, s, t, d, 5'd0);
            K_SLL:   w = r_word(cpu_isa_pkg::F_SLL, 0, t, d, sh);
            K_SRL:   w = r_word(cpu_isa_pkg::F_SRL, 0, t, d, sh);
            K_BADOP: w = i_word(6'h3f, s, d, imm);
            K_BADFN: w = r_word(6'h08, s, t, d, 5'd0);
            default: w = '0;
        endcase
        // expected results, 32-bit wraparound for add and sub
        case (kind)
            K_ORI:   v = a | {16'h0000, imm};
            K_ANDI:  v = a & {16'h0000, imm};
            K_XORI:  v = a ^ {16'h0000, imm};
            K_LUI:   v = {imm, 16'h0000};
            K_OR:    v = a | b;
            K_AND:   v = a & b;
            K_XOR:   v = a ^ b;
            K_NOR:   v = ~(a | b);
            K_ADDU:  v = a + b;
            K_SUBU:  v = a - b;
            K_SLL:   v = b << sh;
            K_SRL:   v = b >> sh;
            default: v = '0;
        endcase
        we = !(kind == K_NOP || kind == K_BADOP || kind == K_BADFN) && d != 0;
        inst_tab[n_prog] = w;
        exp_we[n_prog]   = we;
        exp_reg[n_prog]  = d[4:0];
        exp_val[n_prog]  = v;
        if (we) begin
            ref_regs[d] = v;
        end
        n_prog++;
    endtask

    task automatic build_program();
        add_instr(K_LUI, 1, 0, 0);
        add_instr(K_ORI, 1, 1, 0);
        add_instr(K_LUI, 2, 0, 0);
        add_instr(K_XORI, 2, 2, 0);
        add_instr(K_ANDI, 3, 1, 0);
        add_instr(K_OR, 4, 1, 2);
        add_instr(K_AND, 5, 4, 1);
        add_instr(K_XOR, 6, 4, 2);
        add_instr(K_NOR, 7, 4, 6);
        add_instr(K_ADDU, 8, 7, 1);
        // 0 - r8 wraps, then a doubling that overflows
        add_instr(K_SUBU, 9, 0, 8);
        add_instr(K_ADDU, 10, 9, 9);
        add_instr(K_SLL, 11, 0, 10);
        add_instr(K_SRL, 12, 0, 11);
        add_instr(K_ORI, 0, 1, 0);
        add_instr(K_ADDU, 0, 1, 2);
        add_instr(K_OR, 13, 0, 12);
        add_instr(K_BADOP, 14, 1, 0);
        add_instr(K_BADFN, 14, 1, 2);
        add_instr(K_NOP, 0, 0, 0);
        add_instr(K_XORI, 13, 13, 0);
        add_instr(K_SUBU, 14, 13, 12);
        add_instr(K_NOP, 0, 0, 0);
        add_instr(K_NOP, 0, 0, 0);
        add_instr(K_OR, 15, 14, 14);
        add_instr(K_SLL, 16, 0, 15);
        add_instr(K_SRL, 17, 0, 16);
        add_instr(K_AND, 18, 17, 15);
        add_instr(K_ADDU, 19, 18, 10);
        add_instr(K_LUI, 20, 0, 0);
        // r20 in both execute and memory, the younger value must win
        add_instr(K_ORI, 20, 20, 0);
        add_instr(K_XOR, 21, 20, 19);
    endtask

    // rom model, one word per address
    initial begin
        rom_data_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ce_o && rom_addr_o < cpu_pipe_pkg::word_t'(4 * n_prog)) begin
                rom_data_i = inst_tab[rom_addr_o >> 2];
            end else begin
                rom_data_i = '0;
            end
        end
    end

    // monitor, sampled mid-cycle
    always @(negedge clk) begin
        int idx;
        cyc++;
        if (!arst_n_i) begin
            if (rom_ce_o || commit_we_o) begin
                n_other_err++;
                $display("time %0t: chip enable or commit strobe high during reset", $time);
            end
        end else begin
            if (rom_ce_o) begin
                n_checks++;
                if (!seen_first && rom_addr_o != `CPU_RESET_PC) begin
                    n_other_err++;
                    $display("time %0t: first fetch address is %h, not zero", $time, rom_addr_o);
                end
                if (seen_first && rom_addr_o != prev_addr + 32'd4) begin
                    n_other_err++;
                    $display("time %0t: fetch address %h does not follow %h by 4",
                             $time, rom_addr_o, prev_addr);
                end
                if (rom_addr_o < cpu_pipe_pkg::word_t'(4 * n_prog)) begin
                    issue_cyc[rom_addr_o >> 2] = cyc;
                end
                seen_first = 1'b1;
                prev_addr  = rom_addr_o;
            end
            if (commit_we_o) begin
                n_checks++;
                if (exp_q.size() == 0) begin
                    n_other_err++;
                    $display("time %0t: unexpected extra commit to r%0d", $time, commit_addr_o);
                end else begin
                    idx = exp_q.pop_front();
                    if (commit_addr_o != exp_reg[idx] || commit_data_o != exp_val[idx]) begin
                        n_value_err++;
                        $display("[FAIL] time %0t: expected r%0d = %h, got r%0d = %h", $time,
                                 exp_reg[idx], exp_val[idx], commit_addr_o, commit_data_o);
                    end
                    if (cyc != issue_cyc[idx] + 4) begin
                        n_other_err++;
                        $display("time %0t: commit of entry %0d came in cycle %0d, not %0d",
                                 $time, idx, cyc, issue_cyc[idx] + 4);
                    end
                end
            end
        end
    end

    initial begin
        #1;
        repeat (10 * (n_prog + 20)) @(posedge clk);
        $display("timeout: the program did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        arst_n_i    = 1'b0;
        lfsr_state  = 16'd21965;
        n_prog      = 0;
        cyc         = 0;
        n_checks    = 0;
        n_value_err = 0;
        n_other_err = 0;
        seen_first  = 1'b0;
        prev_addr   = '0;
        for (int r = 0; r < `CPU_NREGS; r++) begin
            ref_regs[r] = '0;
        end
        build_program();
        // entries that write, in program order
        for (int e = 0; e < n_prog; e++) begin
            if (exp_we[e]) begin
                exp_q.push_back(e);
            end
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        // run until every table address was fetched, then drain the pipe
        while (!(rom_ce_o && rom_addr_o >= cpu_pipe_pkg::word_t'(4 * n_prog))) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        if (exp_q.size() != 0) begin
            n_other_err++;
            $display("%0d expected commits never arrived", exp_q.size());
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/cpu_pipe_pkg.sv
logic/cpu_isa_pkg.sv
logic/pc_fetch.sv
logic/regfile.sv
logic/decode.sv
logic/execute.sv
logic/writeback_pipe.sv
logic/cpu.sv
verif/cpu_tb.sv
